// File: common/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

//////////////////////////////////////////////////
// frame geometry
//////////////////////////////////////////////////

// input frame size in pixels, raster order
`define IMG_WIDTH   12
`define IMG_HEIGHT  12

//////////////////////////////////////////////////
// filter geometry
//////////////////////////////////////////////////

// kernel side, square kernel
`define FILTER_SIZE 5
// taps per kernel
`define NUM_TAPS    (`FILTER_SIZE * `FILTER_SIZE)
// parallel filter engines
`define NUM_FILTERS 6

//////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////

// unsigned input pixel
`define PIX_W       8
// signed weights and biases
`define COEF_W      16
// full precision feature, no truncation
`define ACC_W       32

`endif

// File: common/conv_pkg.sv
`default_nettype none

package conv_pkg;

    `include "conv_macros.svh"

    //////////////////////////////////////////////////
    // scalar types
    //////////////////////////////////////////////////

    // raw input pixel
    typedef logic        [`PIX_W-1:0]  pixel_t;
    // kernel weight or bias
    typedef logic signed [`COEF_W-1:0] coef_t;
    // accumulated feature value
    typedef logic signed [`ACC_W-1:0]  acc_t;

    //////////////////////////////////////////////////
    // window path
    //////////////////////////////////////////////////

    // tap index = row * FILTER_SIZE + column
    // row 0 is the oldest line, column 0 the oldest pixel
    typedef pixel_t [`NUM_TAPS-1:0] window_t;

    // one window plus end of frame marker
    typedef struct packed {
        window_t win;
        logic    last;
    } window_beat_t;

    //////////////////////////////////////////////////
    // coefficient write port
    //////////////////////////////////////////////////

    // taps 0..NUM_TAPS-1 are weights, tap NUM_TAPS is the bias
    typedef struct packed {
        logic [2:0] filt_idx;
        logic [4:0] tap_idx;
        coef_t      value;
    } coef_wr_t;

    //////////////////////////////////////////////////
    // result path
    //////////////////////////////////////////////////

    // one feature per filter lane
    typedef acc_t [`NUM_FILTERS-1:0] feature_vec_t;

    typedef struct packed {
        feature_vec_t features;
        logic         last;
    } result_t;

endpackage

`default_nettype wire

// File: source/window_gen/conv_window_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_window_gen import conv_pkg::*; (
    input  wire logic         i_clk,
    input  wire logic         i_rst,
    // pixel stream in
    input  wire logic         i_pix_valid,
    input  wire pixel_t       i_pix,
    output logic              o_pix_ready,
    // window stream out
    input  wire logic         i_win_ready,
    output logic              o_win_valid,
    output window_beat_t      o_win
);

    localparam int COL_W = $clog2(`IMG_WIDTH);
    localparam int ROW_W = $clog2(`IMG_HEIGHT);

    // frame position of the pixel on the input
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;

    // one short column per frame column holding the last four rows
    // element 0 is the oldest row
    pixel_t [`FILTER_SIZE-2:0] line_buf [`IMG_WIDTH];

    // five pixels of the current column, new pixel on top
    pixel_t [`FILTER_SIZE-1:0] new_col;

    logic pix_accept;
    logic col_end;
    logic row_end;
    logic win_complete;

    //////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////

    // stall only while a window waits on the engines
    assign o_pix_ready = !o_win_valid || i_win_ready;
    assign pix_accept  = i_pix_valid && o_pix_ready;

    //////////////////////////////////////////////////
    // frame counters
    //////////////////////////////////////////////////

    assign col_end = (col_cnt == COL_W'(`IMG_WIDTH - 1));
    assign row_end = (row_cnt == ROW_W'(`IMG_HEIGHT - 1));

    // a window is complete once four earlier rows and columns exist
    assign win_complete = (col_cnt >= COL_W'(`FILTER_SIZE - 1)) &&
                          (row_cnt >= ROW_W'(`FILTER_SIZE - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (pix_accept) begin
            if (col_end) begin
                col_cnt <= '0;
                // wrap to the next frame, frames run back to back
                if (row_end) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // line buffer
    //////////////////////////////////////////////////

    // buffered rows below, incoming pixel as the newest row
    assign new_col = {i_pix, line_buf[col_cnt]};

    always_ff @(posedge i_clk) begin
        if (pix_accept) begin
            // drop the oldest row of this column
            line_buf[col_cnt] <= new_col[`FILTER_SIZE-1:1];
        end
    end

    //////////////////////////////////////////////////
    // window register
    //////////////////////////////////////////////////

    // shift left by one column, new column enters at column 4
    always_ff @(posedge i_clk) begin
        if (pix_accept) begin
            for (int r = 0; r < `FILTER_SIZE; r++) begin
                for (int c = 0; c < `FILTER_SIZE - 1; c++) begin
                    o_win.win[r*`FILTER_SIZE + c] <= o_win.win[r*`FILTER_SIZE + c + 1];
                end
                o_win.win[r*`FILTER_SIZE + `FILTER_SIZE - 1] <= new_col[r];
            end
            // bottom right window closes the frame
            o_win.last <= col_end && row_end;
        end
    end

    // window valid follows the completing pixel by one edge
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_win_valid <= 1'b0;
        end else if (pix_accept) begin
            o_win_valid <= win_complete;
        end else if (i_win_ready) begin
            o_win_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/filter_engine/conv_filter_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_filter_engine import conv_pkg::*; #(
    parameter int FILTER_INDEX = 0
) (
    input  wire logic         i_clk,
    input  wire logic         i_rst,
    // coefficient write strobe
    input  wire logic         i_coef_wr,
    input  wire coef_wr_t     i_coef,
    // common pipeline enable
    input  wire logic         i_en,
    // window in
    input  wire logic         i_win_valid,
    input  wire window_beat_t i_win,
    // feature out
    output logic              o_valid,
    output logic              o_last,
    output acc_t              o_feature
);

    // 25 -> 13 -> 7 -> 4 -> 2 -> 1
    localparam int TREE_LEVELS = $clog2(`NUM_TAPS);

    coef_t [`NUM_TAPS-1:0] weights;
    coef_t                 bias;

    //////////////////////////////////////////////////
    // coefficient registers
    //////////////////////////////////////////////////

    // only writes addressed to this lane are taken
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            weights <= '0;
            bias    <= '0;
        end else if (i_coef_wr && (i_coef.filt_idx == 3'(FILTER_INDEX))) begin
            if (i_coef.tap_idx < 5'(`NUM_TAPS)) begin
                weights[i_coef.tap_idx] <= i_coef.value;
            end else if (i_coef.tap_idx == 5'(`NUM_TAPS)) begin
                bias <= i_coef.value;
            end
        end
    end

    //////////////////////////////////////////////////
    // multiply stage and adder tree
    //////////////////////////////////////////////////

    // level 0 holds the products, each further level halves the node count
    for (genvar l = 0; l <= TREE_LEVELS; l++) begin : g_lvl
        localparam int N_OUT = (`NUM_TAPS + (1 << l) - 1) >> l;

        acc_t node [N_OUT];
        logic vld;
        logic last;

        if (l == 0) begin : g_mult
            // pixel is zero extended so it multiplies as a positive value
            always_ff @(posedge i_clk) begin
                if (i_en) begin
                    for (int k = 0; k < N_OUT; k++) begin
                        node[k] <= $signed({1'b0, i_win.win[k]}) * weights[k];
                    end
                    last <= i_win.last;
                end
            end

            always_ff @(posedge i_clk) begin
                if (i_rst) begin
                    vld <= 1'b0;
                end else if (i_en) begin
                    vld <= i_win_valid;
                end
            end
        end else begin : g_add
            localparam int N_IN = (`NUM_TAPS + (1 << (l - 1)) - 1) >> (l - 1);

            // pairwise sums, an odd node at the end passes straight up
            always_ff @(posedge i_clk) begin
                if (i_en) begin
                    for (int k = 0; k < N_OUT; k++) begin
                        if (2*k + 1 < N_IN) begin
                            node[k] <= g_lvl[l-1].node[2*k] + g_lvl[l-1].node[2*k + 1];
                        end else begin
                            node[k] <= g_lvl[l-1].node[2*k];
                        end
                    end
                    last <= g_lvl[l-1].last;
                end
            end

            always_ff @(posedge i_clk) begin
                if (i_rst) begin
                    vld <= 1'b0;
                end else if (i_en) begin
                    vld <= g_lvl[l-1].vld;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // bias stage
    //////////////////////////////////////////////////

    // bias is sign extended into the full accumulator width
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_feature <= g_lvl[TREE_LEVELS].node[0] + bias;
            o_last    <= g_lvl[TREE_LEVELS].last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (i_en) begin
            o_valid <= g_lvl[TREE_LEVELS].vld;
        end
    end

endmodule

`default_nettype wire

// File: source/conv_output_collector.sv
`timescale 1ns/1ps
`default_nettype none

module conv_output_collector import conv_pkg::*; (
    input  wire logic         i_clk,
    input  wire logic         i_rst,
    // lanes from the engines, all in lockstep
    input  wire logic         i_lane_valid,
    input  wire logic         i_lane_last,
    input  wire feature_vec_t i_lane_features,
    // result stream out
    input  wire logic         i_res_ready,
    output logic              o_eng_ready,
    output logic              o_res_valid,
    output result_t           o_res
);

    //////////////////////////////////////////////////
    // result register
    //////////////////////////////////////////////////

    // free when empty or drained this cycle
    // this also stalls every engine stage and the window generator
    assign o_eng_ready = !o_res_valid || i_res_ready;

    // payload only moves while the pipeline advances
    always_ff @(posedge i_clk) begin
        if (o_eng_ready) begin
            o_res.features <= i_lane_features;
            o_res.last     <= i_lane_last;
        end
    end

    // valid drops when read with nothing new behind it
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_res_valid <= 1'b0;
        end else if (o_eng_ready) begin
            o_res_valid <= i_lane_valid;
        end
    end

endmodule

`default_nettype wire

// File: source/conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_layer import conv_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    // pixel stream
    input  wire logic     i_pix_valid,
    input  wire pixel_t   i_pix,
    output logic          o_pix_ready,
    // coefficient writes, only while the datapath is empty
    input  wire logic     i_coef_wr,
    input  wire coef_wr_t i_coef,
    // result stream
    input  wire logic     i_res_ready,
    output logic          o_res_valid,
    output result_t       o_res
);

    // window generator to engines
    logic         win_valid;
    window_beat_t win;

    // common stall for the whole datapath
    logic         eng_ready;

    // per lane outputs, lanes move together
    logic [`NUM_FILTERS-1:0] eng_valid;
    logic [`NUM_FILTERS-1:0] eng_last;
    feature_vec_t            eng_features;

    //////////////////////////////////////////////////
    // window generation
    //////////////////////////////////////////////////

    conv_window_gen window_gen_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_pix_ready (o_pix_ready),
        .i_win_ready (eng_ready),
        .o_win_valid (win_valid),
        .o_win       (win)
    );

    //////////////////////////////////////////////////
    // filter engines
    //////////////////////////////////////////////////

    for (genvar f = 0; f < `NUM_FILTERS; f++) begin : g_engine
        conv_filter_engine #(
            .FILTER_INDEX (f)
        ) filter_engine_inst (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_coef_wr   (i_coef_wr),
            .i_coef      (i_coef),
            .i_en        (eng_ready),
            .i_win_valid (win_valid),
            .i_win       (win),
            .o_valid     (eng_valid[f]),
            .o_last      (eng_last[f]),
            .o_feature   (eng_features[f])
        );
    end

    //////////////////////////////////////////////////
    // output collection
    //////////////////////////////////////////////////

    // lane 0 speaks for the control of every lane
    conv_output_collector output_collector_inst (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_lane_valid    (eng_valid[0]),
        .i_lane_last     (eng_last[0]),
        .i_lane_features (eng_features),
        .i_res_ready     (i_res_ready),
        .o_eng_ready     (eng_ready),
        .o_res_valid     (o_res_valid),
        .o_res           (o_res)
    );

endmodule

`default_nettype wire

// File: verification/conv_layer_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_layer_sva import conv_pkg::*; (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst,
    input  wire logic                    i_res_ready,
    input  wire logic                    i_res_valid,
    input  wire result_t                 i_res,
    input  wire logic                    i_pix_ready,
    input  wire logic [`NUM_FILTERS-1:0] i_eng_valid,
    input  wire logic [`NUM_FILTERS-1:0] i_eng_last
);

    // read by the testbench for its final verdict
    int fail_count = 0;

    //////////////////////////////////////////////////
    // result handshake
    //////////////////////////////////////////////////

    // a stalled beat stays put until taken
    a_res_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_res_valid && !i_res_ready) |=> (i_res_valid && $stable(i_res)))
    else begin
        fail_count++;
        $error("result changed while stalled");
    end

    // input only stalls behind a pending result
    a_pix_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_res_valid |-> i_pix_ready)
    else begin
        fail_count++;
        $error("pixel ready low with no result pending");
    end

    //////////////////////////////////////////////////
    // lane alignment
    //////////////////////////////////////////////////

    // every engine sees the same windows and the same enable
    a_lane_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        i_eng_valid == {`NUM_FILTERS{i_eng_valid[0]}})
    else begin
        fail_count++;
        $error("engine valids out of step");
    end

    a_lane_last: assert property (@(posedge i_clk) disable iff (i_rst)
        i_eng_valid[0] |-> (i_eng_last == {`NUM_FILTERS{i_eng_last[0]}}))
    else begin
        fail_count++;
        $error("engine last flags out of step");
    end

endmodule

bind conv_layer conv_layer_sva conv_layer_sva_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_res_ready (i_res_ready),
    .i_res_valid (o_res_valid),
    .i_res       (o_res),
    .i_pix_ready (o_pix_ready),
    .i_eng_valid (eng_valid),
    .i_eng_last  (eng_last)
);

`default_nettype wire

// File: verification/conv_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_layer_tb import conv_pkg::*; ();

    localparam int W          = `IMG_WIDTH;
    localparam int H          = `IMG_HEIGHT;
    localparam int FS         = `FILTER_SIZE;
    localparam int FRAME_PIX  = W * H;
    localparam int WIN_FRAME  = (W - FS + 1) * (H - FS + 1);
    localparam int NUM_FRAMES = 6;
    localparam int TIMEOUT    = NUM_FRAMES * FRAME_PIX * 4 + 1000;

    logic     i_clk;
    logic     i_rst;
    logic     i_pix_valid;
    pixel_t   i_pix;
    logic     o_pix_ready;
    logic     i_coef_wr;
    coef_wr_t i_coef;
    logic     i_res_ready;
    logic     o_res_valid;
    result_t  o_res;

    // model copy of coefficients with the bias as the last tap
    int       weight [`NUM_FILTERS][`NUM_TAPS+1];
    pixel_t   send_q [$];
    result_t  exp_q [$];
    bit       res_random = 1'b0;
    bit       pix_gaps   = 1'b0;
    int       errors = 0;
    int       beats_in_frame = 0;
    int       frames_seen = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       err_start = 0;
    int       frm_start = 0;
    int       sva_start = 0;
    int       sva_errors;

    assign sva_errors = conv_layer_inst.conv_layer_sva_inst.fail_count;

    conv_layer conv_layer_inst (.*);

    //////////////////////////////////////////////////
    // clock, sink and watchdog
    //////////////////////////////////////////////////

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // sink ready with random back-pressure when enabled
    initial begin
        i_res_ready = 1'b1;
        forever begin
            @(posedge i_clk);
            #1;
            i_res_ready = res_random ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    initial begin
        repeat (TIMEOUT) @(posedge i_clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("Test failures found");
        $finish;
    end

    //////////////////////////////////////////////////
    // result checking
    //////////////////////////////////////////////////

    // values before the edge updates are the transferred beat
    always @(posedge i_clk) begin : check_results
        result_t want;
        if (!i_rst && o_res_valid && i_res_ready) begin
            if (exp_q.size() == 0) begin
                $display("extra result beat at %0t with nothing expected", $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                for (int f = 0; f < `NUM_FILTERS; f++) begin
                    assert (o_res.features[f] == want.features[f]) else begin
                        $display("error @%0t: filter %0d got %0d expected %0d", $time, f,
                                 o_res.features[f], want.features[f]);
                        errors++;
                    end
                end
                assert (o_res.last == want.last) else begin
                    $display("error @%0t: last got %0b expected %0b", $time, o_res.last,
                             want.last);
                    errors++;
                end
            end
            beats_in_frame++;
            if (o_res.last) begin
                assert (beats_in_frame == WIN_FRAME) else begin
                    $display("error @%0t: frame had %0d beats expected %0d", $time,
                             beats_in_frame, WIN_FRAME);
                    errors++;
                end
                beats_in_frame = 0;
                frames_seen++;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus and reference model
    //////////////////////////////////////////////////

    task automatic write_coefs();
        coef_t val;
        for (int f = 0; f < `NUM_FILTERS; f++) begin
            for (int t = 0; t <= `NUM_TAPS; t++) begin
                val          = coef_t'($urandom);
                weight[f][t] = int'(val);
                i_coef_wr    = 1'b1;
                i_coef       = '{filt_idx: 3'(f), tap_idx: 5'(t), value: val};
                @(posedge i_clk);
                #1;
            end
        end
        i_coef_wr = 1'b0;
    endtask

    // random frame and its expected beats in raster order of window positions
    task automatic add_frame();
        pixel_t  pix [FRAME_PIX];
        result_t want;
        int      acc;
        for (int p = 0; p < FRAME_PIX; p++) begin
            pix[p] = pixel_t'($urandom);
            send_q.push_back(pix[p]);
        end
        for (int r = FS - 1; r < H; r++) begin
            for (int c = FS - 1; c < W; c++) begin
                for (int f = 0; f < `NUM_FILTERS; f++) begin
                    acc = weight[f][`NUM_TAPS];
                    for (int i = 0; i < FS; i++) begin
                        for (int j = 0; j < FS; j++) begin
                            acc += weight[f][i*FS + j] *
                                   int'(pix[(r - FS + 1 + i) * W + c - FS + 1 + j]);
                        end
                    end
                    want.features[f] = acc;
                end
                want.last = (r == H - 1) && (c == W - 1);
                exp_q.push_back(want);
            end
        end
    endtask

    task automatic stream_pixels();
        while (send_q.size() > 0) begin
            i_pix_valid = 1'b1;
            i_pix       = send_q.pop_front();
            @(posedge i_clk);
            while (!o_pix_ready) @(posedge i_clk);
            #1;
            i_pix_valid = 1'b0;
            // idle cycles between pixels
            if (pix_gaps && $urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) @(posedge i_clk);
                #1;
            end
        end
    endtask

    // wait out every expected beat and idle on so that extra beats show up
    task automatic drain();
        while (exp_q.size() > 0) @(posedge i_clk);
        repeat (20) @(posedge i_clk);
        #1;
    endtask

    task automatic end_test(input string name, input int frames_sent);
        if (frames_seen - frm_start != frames_sent) begin
            $display("frame count wrong in %s: saw %0d frames but sent %0d", name,
                     frames_seen - frm_start, frames_sent);
            errors++;
        end
        tests_run++;
        if (errors != err_start || sva_errors != sva_start) begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        err_start = errors;
        frm_start = frames_seen;
        sva_start = sva_errors;
    endtask

    initial begin
        void'($urandom(32'h8be7cf4f));
        i_rst       = 1'b1;
        i_pix_valid = 1'b0;
        i_pix       = '0;
        i_coef_wr   = 1'b0;
        i_coef      = '0;
        repeat (16) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        assert (!o_res_valid && o_pix_ready) else begin
            $display("error @%0t: after reset valid %0b ready %0b", $time, o_res_valid,
                     o_pix_ready);
            errors++;
        end
        end_test("reset state", 0);

        write_coefs();
        add_frame();
        stream_pixels();
        drain();
        end_test("full rate frame", 1);

        add_frame();
        add_frame();
        stream_pixels();
        drain();
        end_test("back to back frames", 2);

        res_random = 1'b1;
        add_frame();
        stream_pixels();
        drain();
        end_test("random back-pressure", 1);

        res_random = 1'b0;
        pix_gaps   = 1'b1;
        add_frame();
        stream_pixels();
        drain();
        end_test("input gaps", 1);

        // pipeline is empty here so new coefficients are legal
        res_random = 1'b1;
        write_coefs();
        add_frame();
        stream_pixels();
        drain();
        end_test("new coefficients", 1);

        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion errors",
                 tests_run, tests_failed, errors, sva_errors);
        if (tests_failed == 0 && errors == 0 && sva_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/conv_pkg.sv
source/window_gen/conv_window_gen.sv
source/filter_engine/conv_filter_engine.sv
source/conv_output_collector.sv
source/conv_layer.sv
verification/conv_layer_sva.sv
verification/conv_layer_tb.sv

// File: Bender.yml
package:
  name: conv_layer

export_include_dirs:
  - common

sources:
  - common/conv_pkg.sv
  - source/window_gen/conv_window_gen.sv
  - source/filter_engine/conv_filter_engine.sv
  - source/conv_output_collector.sv
  - source/conv_layer.sv
  - target: simulation
    files:
      - verification/conv_layer_sva.sv
      - verification/conv_layer_tb.sv
